//--- usb_bulk_pkg.sv
package usb_bulk_pkg;

  // PID nibble as carried on tuser, kind in [3:2] and class in [1:0]
  typedef logic [3:0] pid_t;

  // PID classes
  localparam logic [1:0] CLS_TOKEN = 2'b01;
  localparam logic [1:0] CLS_HSK = 2'b10;
  localparam logic [1:0] CLS_DATA = 2'b11;

  // Token kinds
  localparam logic [1:0] TOK_OUT = 2'b00;
  localparam logic [1:0] TOK_IN = 2'b10;
  localparam logic [1:0] TOK_SETUP = 2'b11;

  // Data kinds
  localparam logic [1:0] DATA0 = 2'b00;
  localparam logic [1:0] DATA1 = 2'b10;

  // Handshake kinds
  localparam logic [1:0] HSK_ACK = 2'b00;
  localparam logic [1:0] HSK_NAK = 2'b10;

  typedef enum logic [2:0] {
    BLK_IDLE,
    BLK_DATI_TX,
    BLK_DATI_ZDP,
    BLK_DATI_ACK,
    BLK_DATO_RX,
    BLK_DATO_ERR,
    BLK_DATO_HSK,
    BLK_DONE
  } bulk_state_t;

  typedef enum logic [2:0] {
    ER_NONE = 3'd0,
    ER_TOKN = 3'd3,
    ER_ADDR = 3'd4,
    ER_ENDP = 3'd5
  } err_code_t;

endpackage

//--- bulk_state_if.sv
interface bulk_state_if;

  // Current bulk transaction state
  usb_bulk_pkg::bulk_state_t state;

  // High from the cycle after an accepted token until back in idle
  logic busy;

  // Accepted IN token, valid in the token cycle only
  logic tok_in;

  // Application IN readiness captured with the IN token
  logic in_ready_q;

  modport fsm_mp(output state, output busy, output tok_in, output in_ready_q);

  modport view_mp(input state, input busy, input tok_in, input in_ready_q);

endinterface

//--- bulk_transfer_fsm.sv
module bulk_transfer_fsm #(
  parameter logic [3:0] BULK_ENDPOINT = 4'd1
) (
  input  logic clock,
  input  logic reset,
  input  logic [6:0] usb_addr_i,
  input  logic tok_recv_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  usb_bulk_pkg::pid_t usb_tuser_i,
  input  logic usb_recv_i,
  input  logic usb_sent_i,
  input  logic hsk_recv_i,
  input  logic hsk_sent_i,
  input  logic timeout_i,
  input  logic blk_in_ready_i,
  input  logic blk_out_ready_i,
  input  logic usb_tvalid_i,
  input  logic usb_tlast_i,
  input  logic blk_tready_i,
  output logic usb_tready_o,
  output logic blk_tvalid_o,
  output logic blk_start_o,
  output logic blk_fetch_o,
  output logic blk_store_o,
  output usb_bulk_pkg::err_code_t err_code_o,
  output logic idle_o,
  bulk_state_if.fsm_mp state_if
);

  usb_bulk_pkg::bulk_state_t state_q;
  usb_bulk_pkg::err_code_t err_q;
  logic start_q;
  logic fetch_q;
  logic store_q;
  logic in_ready_q;
  logic recv_seen_q;

  logic tok_w;
  logic bulk_kind_w;
  logic accept_w;
  logic is_in_w;
  logic dato_w;
  logic recv_w;
  logic pend_w;

  // Only tokens seen while idle take part in dispatch
  assign tok_w = tok_recv_i && usb_tuser_i[1:0] == usb_bulk_pkg::CLS_TOKEN &&
                 state_q == usb_bulk_pkg::BLK_IDLE;
  assign is_in_w = usb_tuser_i[3:2] == usb_bulk_pkg::TOK_IN;
  assign bulk_kind_w = is_in_w || usb_tuser_i[3:2] == usb_bulk_pkg::TOK_OUT;
  assign accept_w = tok_w && tok_addr_i == usb_addr_i && bulk_kind_w &&
                    tok_endp_i == BULK_ENDPOINT;

  // A stalled OUT beat keeps the packet open even after usb_recv_i
  assign dato_w = state_q == usb_bulk_pkg::BLK_DATO_RX || state_q == usb_bulk_pkg::BLK_DATO_ERR;
  assign recv_w = usb_recv_i || recv_seen_q;
  assign pend_w = usb_tvalid_i && !(usb_tlast_i && usb_tready_o);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_bulk_pkg::BLK_IDLE;
      recv_seen_q <= 1'b0;
    end else begin
      recv_seen_q <= dato_w && recv_w && pend_w;
      case (state_q)
        usb_bulk_pkg::BLK_IDLE: begin
          if (accept_w && is_in_w) begin
            state_q <= blk_in_ready_i ? usb_bulk_pkg::BLK_DATI_TX : usb_bulk_pkg::BLK_DATI_ZDP;
          end else if (accept_w) begin
            state_q <= blk_out_ready_i ? usb_bulk_pkg::BLK_DATO_RX : usb_bulk_pkg::BLK_DATO_ERR;
          end
        end
        usb_bulk_pkg::BLK_DATI_TX, usb_bulk_pkg::BLK_DATI_ZDP: begin
          if (usb_sent_i) begin
            state_q <= usb_bulk_pkg::BLK_DATI_ACK;
          end
        end
        usb_bulk_pkg::BLK_DATI_ACK: begin
          // Host ACK, or give up once the turnaround timer expires
          if (hsk_recv_i || timeout_i) begin
            state_q <= usb_bulk_pkg::BLK_DONE;
          end
        end
        usb_bulk_pkg::BLK_DATO_RX, usb_bulk_pkg::BLK_DATO_ERR: begin
          if (recv_w && !pend_w) begin
            state_q <= usb_bulk_pkg::BLK_DATO_HSK;
          end
        end
        usb_bulk_pkg::BLK_DATO_HSK: begin
          if (hsk_sent_i) begin
            state_q <= usb_bulk_pkg::BLK_DONE;
          end
        end
        usb_bulk_pkg::BLK_DONE: begin
          state_q <= usb_bulk_pkg::BLK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      err_q <= usb_bulk_pkg::ER_NONE;
    end else if (tok_w && tok_addr_i != usb_addr_i) begin
      err_q <= usb_bulk_pkg::ER_NONE;
    end else if (tok_w) begin
      case (usb_tuser_i[3:2])
        usb_bulk_pkg::TOK_IN, usb_bulk_pkg::TOK_OUT: begin
          err_q <= accept_w ? usb_bulk_pkg::ER_NONE : usb_bulk_pkg::ER_ENDP;
        end
        usb_bulk_pkg::TOK_SETUP: begin
          err_q <= usb_bulk_pkg::ER_TOKN;
        end
        // SOF has no device address
        default: begin
          err_q <= usb_bulk_pkg::ER_NONE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= 1'b0;
      fetch_q <= 1'b0;
      store_q <= 1'b0;
      in_ready_q <= 1'b0;
    end else begin
      start_q <= accept_w;
      if (accept_w) begin
        fetch_q <= is_in_w && blk_in_ready_i;
        store_q <= !is_in_w && blk_out_ready_i;
        in_ready_q <= blk_in_ready_i;
      end else if (state_q == usb_bulk_pkg::BLK_DONE) begin
        fetch_q <= 1'b0;
        store_q <= 1'b0;
      end
    end
  end

  // OUT beats reach the application only in DATO_RX, elsewhere they drain
  assign usb_tready_o = state_q == usb_bulk_pkg::BLK_DATO_RX ? blk_tready_i : 1'b1;
  assign blk_tvalid_o = state_q == usb_bulk_pkg::BLK_DATO_RX && usb_tvalid_i;

  assign blk_start_o = start_q;
  assign blk_fetch_o = fetch_q;
  assign blk_store_o = store_q;
  assign err_code_o = err_q;
  assign idle_o = state_q == usb_bulk_pkg::BLK_IDLE;

  assign state_if.state = state_q;
  assign state_if.busy = state_q != usb_bulk_pkg::BLK_IDLE;
  assign state_if.tok_in = accept_w && is_in_w;
  assign state_if.in_ready_q = in_ready_q;

endmodule

//--- data_toggle.sv
module data_toggle (
  input  logic clock,
  input  logic reset,
  input  logic config_event_i,
  input  logic usb_recv_i,
  input  usb_bulk_pkg::pid_t usb_tuser_i,
  input  logic hsk_recv_i,
  output logic parity_o,
  bulk_state_if.view_mp state_if
);

  logic parity_q;
  logic out_match_w;
  logic in_ack_w;

  // OUT packet carrying the expected DATA0/DATA1 kind
  assign out_match_w = usb_recv_i && state_if.state == usb_bulk_pkg::BLK_DATO_RX &&
                       usb_tuser_i[1:0] == usb_bulk_pkg::CLS_DATA &&
                       usb_tuser_i[3:2] == (parity_q ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0);

  // Host accepted our IN packet
  assign in_ack_w = hsk_recv_i && state_if.state == usb_bulk_pkg::BLK_DATI_ACK &&
                    usb_tuser_i == {usb_bulk_pkg::HSK_ACK, usb_bulk_pkg::CLS_HSK};

  always_ff @(posedge clock) begin
    if (reset || config_event_i) begin
      parity_q <= 1'b0;
    end else if (out_match_w || in_ack_w) begin
      parity_q <= !parity_q;
    end
  end

  assign parity_o = parity_q;

endmodule

//--- eop_handshake.sv
module eop_handshake #(
  parameter int EOP_DELAY = 5
) (
  input  logic clock,
  input  logic reset,
  input  logic usb_recv_i,
  input  logic hsk_sent_i,
  output logic hsk_send_o,
  output usb_bulk_pkg::pid_t hsk_pid_o,
  bulk_state_if.view_mp state_if
);

  localparam int EBITS = $clog2(EOP_DELAY + 1);
  localparam logic [EBITS-1:0] EOP_LOAD = EBITS'(EOP_DELAY);

  logic [EBITS-1:0] count_q;
  logic run_q;
  logic eop_q;
  logic out_q;
  logic nak_q;
  logic hsk_send_q;

  // Countdown from the end of a received packet, then one eop pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      run_q <= 1'b0;
      eop_q <= 1'b0;
      out_q <= 1'b0;
    end else if (usb_recv_i) begin
      run_q <= 1'b1;
      eop_q <= 1'b0;
      out_q <= state_if.state == usb_bulk_pkg::BLK_DATO_RX ||
               state_if.state == usb_bulk_pkg::BLK_DATO_ERR;
    end else if (run_q && count_q == '0) begin
      run_q <= 1'b0;
      eop_q <= 1'b1;
    end else begin
      eop_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_recv_i) begin
      count_q <= EOP_LOAD;
      nak_q <= state_if.state == usb_bulk_pkg::BLK_DATO_ERR;
    end else if (run_q && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Request stays up until the encoder reports the handshake sent
  always_ff @(posedge clock) begin
    if (reset || hsk_sent_i) begin
      hsk_send_q <= 1'b0;
    end else if (eop_q && out_q) begin
      hsk_send_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (eop_q && out_q && !hsk_send_q) begin
      hsk_pid_o <= {nak_q ? usb_bulk_pkg::HSK_NAK : usb_bulk_pkg::HSK_ACK,
                    usb_bulk_pkg::CLS_HSK};
    end
  end

  assign hsk_send_o = hsk_send_q;

endmodule

//--- turnaround_timer.sv
module turnaround_timer #(
  parameter int TURNAROUND_CYCLES = 255
) (
  input  logic clock,
  input  logic reset,
  input  logic usb_sent_i,
  input  logic hsk_sent_i,
  input  logic tok_recv_i,
  input  logic usb_recv_i,
  input  logic hsk_recv_i,
  output logic timeout_o,
  bulk_state_if.view_mp state_if
);

  localparam int TBITS = $clog2(TURNAROUND_CYCLES + 1);
  localparam logic [TBITS-1:0] TIMER_LOAD = TBITS'(TURNAROUND_CYCLES);

  logic [TBITS-1:0] count_q;
  logic armed_q;
  logic busy_q;
  logic timeout_q;
  logic tx_w;
  logic clear_w;

  assign tx_w = usb_sent_i || hsk_sent_i;

  // Any host traffic, or a new transaction, ends the wait
  assign clear_w = tok_recv_i || usb_recv_i || hsk_recv_i || state_if.tok_in ||
                   (state_if.busy && !busy_q);

  always_ff @(posedge clock) begin
    if (reset) begin
      armed_q <= 1'b0;
      busy_q <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      busy_q <= state_if.busy;
      if (tx_w) begin
        armed_q <= 1'b1;
        timeout_q <= 1'b0;
      end else if (clear_w) begin
        armed_q <= 1'b0;
        timeout_q <= 1'b0;
      end else if (armed_q && count_q == '0) begin
        armed_q <= 1'b0;
        timeout_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (tx_w) begin
      count_q <= TIMER_LOAD;
    end else if (armed_q && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign timeout_o = timeout_q;

endmodule

//--- tx_stream_mux.sv
module tx_stream_mux (
  input  logic clock,
  input  logic reset,
  input  logic blk_tvalid_i,
  input  logic blk_tlast_i,
  input  logic blk_tkeep_i,
  input  logic [7:0] blk_tdata_i,
  input  logic usb_tready_i,
  input  logic parity_i,
  input  logic hsk_send_i,
  input  usb_bulk_pkg::pid_t hsk_pid_i,
  output logic blk_tready_o,
  output logic usb_tvalid_o,
  output logic usb_tkeep_o,
  output logic usb_tlast_o,
  output logic [7:0] usb_tdata_o,
  output usb_bulk_pkg::pid_t usb_tuser_o,
  bulk_state_if.view_mp state_if
);

  logic tok_in_q;
  logic zdp_q;
  logic sel_blk_w;
  usb_bulk_pkg::pid_t tuser_q;

  assign sel_blk_w = state_if.state == usb_bulk_pkg::BLK_DATI_TX;

  // Zero-data beat, raised once the IN readiness has been captured
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_in_q <= 1'b0;
      zdp_q <= 1'b0;
    end else begin
      tok_in_q <= state_if.tok_in;
      if (tok_in_q && !state_if.in_ready_q) begin
        zdp_q <= 1'b1;
      end else if (zdp_q && usb_tready_i) begin
        zdp_q <= 1'b0;
      end
    end
  end

  // Data PID follows the endpoint toggle at the IN token
  always_ff @(posedge clock) begin
    if (reset) begin
      tuser_q <= '0;
    end else if (state_if.tok_in) begin
      tuser_q <= {parity_i ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0,
                  usb_bulk_pkg::CLS_DATA};
    end
  end

  assign usb_tvalid_o = sel_blk_w ? blk_tvalid_i : zdp_q;
  assign usb_tlast_o = sel_blk_w ? blk_tlast_i : zdp_q;
  assign usb_tkeep_o = sel_blk_w && blk_tkeep_i;
  assign usb_tdata_o = sel_blk_w ? blk_tdata_i : 8'h00;
  assign blk_tready_o = sel_blk_w && usb_tready_i;

  // Handshake PID takes over for as long as the request is up
  assign usb_tuser_o = hsk_send_i ? hsk_pid_i : tuser_q;

endmodule

//--- usb_bulk_transactor.sv
module usb_bulk_transactor #(
  parameter logic [3:0] BULK_ENDPOINT = 4'd1,
  parameter int EOP_DELAY = 5,
  parameter int TURNAROUND_CYCLES = 255
) (
  input  logic clock,
  input  logic reset,

  // Device address and decoder events
  input  logic [6:0] usb_addr_i,
  input  logic tok_recv_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic usb_recv_i,
  input  logic usb_sent_i,
  input  logic hsk_recv_i,
  input  logic hsk_sent_i,
  output logic hsk_send_o,
  input  logic config_event_i,

  // OUT data from the decoder
  input  logic usb_tvalid_i,
  output logic usb_tready_o,
  input  logic usb_tkeep_i,
  input  logic usb_tlast_i,
  input  usb_bulk_pkg::pid_t usb_tuser_i,
  input  logic [7:0] usb_tdata_i,

  // IN data to the encoder
  output logic usb_tvalid_o,
  input  logic usb_tready_i,
  output logic usb_tkeep_o,
  output logic usb_tlast_o,
  output usb_bulk_pkg::pid_t usb_tuser_o,
  output logic [7:0] usb_tdata_o,

  // Application side
  input  logic blk_in_ready_i,
  input  logic blk_out_ready_i,
  output logic blk_start_o,
  output logic blk_fetch_o,
  output logic blk_store_o,

  output logic blk_tvalid_o,
  input  logic blk_tready_i,
  output logic blk_tlast_o,
  output logic blk_tkeep_o,
  output logic [7:0] blk_tdata_o,

  input  logic blk_tvalid_i,
  output logic blk_tready_o,
  input  logic blk_tlast_i,
  input  logic blk_tkeep_i,
  input  logic [7:0] blk_tdata_i,

  // Status
  output usb_bulk_pkg::err_code_t err_code_o,
  output logic parity_o,
  output logic usb_timeout_error_o,
  output logic usb_device_idle_o
);

  bulk_state_if bulk_if ();

  logic timeout_w;
  logic parity_w;
  logic hsk_send_w;
  usb_bulk_pkg::pid_t hsk_pid_w;

  // OUT payload goes straight to the application, only tvalid is qualified
  assign blk_tlast_o = usb_tlast_i;
  assign blk_tkeep_o = usb_tkeep_i;
  assign blk_tdata_o = usb_tdata_i;

  assign parity_o = parity_w;
  assign hsk_send_o = hsk_send_w;
  assign usb_timeout_error_o = timeout_w;

  bulk_transfer_fsm #(
    .BULK_ENDPOINT(BULK_ENDPOINT)
  ) u_fsm (
    .clock          (clock),
    .reset          (reset),
    .usb_addr_i     (usb_addr_i),
    .tok_recv_i     (tok_recv_i),
    .tok_addr_i     (tok_addr_i),
    .tok_endp_i     (tok_endp_i),
    .usb_tuser_i    (usb_tuser_i),
    .usb_recv_i     (usb_recv_i),
    .usb_sent_i     (usb_sent_i),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_sent_i     (hsk_sent_i),
    .timeout_i      (timeout_w),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .usb_tvalid_i   (usb_tvalid_i),
    .usb_tlast_i    (usb_tlast_i),
    .blk_tready_i   (blk_tready_i),
    .usb_tready_o   (usb_tready_o),
    .blk_tvalid_o   (blk_tvalid_o),
    .blk_start_o    (blk_start_o),
    .blk_fetch_o    (blk_fetch_o),
    .blk_store_o    (blk_store_o),
    .err_code_o     (err_code_o),
    .idle_o         (usb_device_idle_o),
    .state_if       (bulk_if.fsm_mp)
  );

  data_toggle u_toggle (
    .clock         (clock),
    .reset         (reset),
    .config_event_i(config_event_i),
    .usb_recv_i    (usb_recv_i),
    .usb_tuser_i   (usb_tuser_i),
    .hsk_recv_i    (hsk_recv_i),
    .parity_o      (parity_w),
    .state_if      (bulk_if.view_mp)
  );

  eop_handshake #(
    .EOP_DELAY(EOP_DELAY)
  ) u_eop (
    .clock     (clock),
    .reset     (reset),
    .usb_recv_i(usb_recv_i),
    .hsk_sent_i(hsk_sent_i),
    .hsk_send_o(hsk_send_w),
    .hsk_pid_o (hsk_pid_w),
    .state_if  (bulk_if.view_mp)
  );

  turnaround_timer #(
    .TURNAROUND_CYCLES(TURNAROUND_CYCLES)
  ) u_timer (
    .clock     (clock),
    .reset     (reset),
    .usb_sent_i(usb_sent_i),
    .hsk_sent_i(hsk_sent_i),
    .tok_recv_i(tok_recv_i),
    .usb_recv_i(usb_recv_i),
    .hsk_recv_i(hsk_recv_i),
    .timeout_o (timeout_w),
    .state_if  (bulk_if.view_mp)
  );

  tx_stream_mux u_tx_mux (
    .clock       (clock),
    .reset       (reset),
    .blk_tvalid_i(blk_tvalid_i),
    .blk_tlast_i (blk_tlast_i),
    .blk_tkeep_i (blk_tkeep_i),
    .blk_tdata_i (blk_tdata_i),
    .usb_tready_i(usb_tready_i),
    .parity_i    (parity_w),
    .hsk_send_i  (hsk_send_w),
    .hsk_pid_i   (hsk_pid_w),
    .blk_tready_o(blk_tready_o),
    .usb_tvalid_o(usb_tvalid_o),
    .usb_tkeep_o (usb_tkeep_o),
    .usb_tlast_o (usb_tlast_o),
    .usb_tdata_o (usb_tdata_o),
    .usb_tuser_o (usb_tuser_o),
    .state_if    (bulk_if.view_mp)
  );

endmodule

//--- usb_bulk_transactor_tb.sv
module usb_bulk_transactor_tb;

  localparam logic [6:0] DEV_ADDR = 7'h2a;
  localparam logic [3:0] BULK_EP = 4'd1;

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  logic tok_recv_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic usb_recv_i;
  logic usb_sent_i;
  logic hsk_recv_i;
  logic hsk_sent_i;
  logic hsk_send_o;
  logic config_event_i;
  logic usb_tvalid_i;
  logic usb_tready_o;
  logic usb_tkeep_i;
  logic usb_tlast_i;
  usb_bulk_pkg::pid_t usb_tuser_i;
  logic [7:0] usb_tdata_i;
  logic usb_tvalid_o;
  logic usb_tready_i;
  logic usb_tkeep_o;
  logic usb_tlast_o;
  usb_bulk_pkg::pid_t usb_tuser_o;
  logic [7:0] usb_tdata_o;
  logic blk_in_ready_i;
  logic blk_out_ready_i;
  logic blk_start_o;
  logic blk_fetch_o;
  logic blk_store_o;
  logic blk_tvalid_o;
  logic blk_tready_i;
  logic blk_tlast_o;
  logic blk_tkeep_o;
  logic [7:0] blk_tdata_o;
  logic blk_tvalid_i;
  logic blk_tready_o;
  logic blk_tlast_i;
  logic blk_tkeep_i;
  logic [7:0] blk_tdata_i;
  usb_bulk_pkg::err_code_t err_code_o;
  logic parity_o;
  logic usb_timeout_error_o;
  logic usb_device_idle_o;

  int errors;
  int timeouts;
  int seed_val;
  int cycles;
  bit drain_check;
  logic exp_parity;
  logic [9:0] out_exp_q[$];
  logic [9:0] out_got_q[$];
  logic [9:0] in_exp_q[$];
  logic [9:0] in_got_q[$];

  usb_bulk_transactor dut_i (.*);

  always #50 clock = !clock;

  // Host and application accept beats at random
  always @(posedge clock) begin
    blk_tready_i <= ($urandom % 4) != 0;
    usb_tready_i <= ($urandom % 4) != 0;
  end

  always @(posedge clock) begin
    if (blk_tvalid_o && blk_tready_i) begin
      out_got_q.push_back({blk_tlast_o, blk_tkeep_o, blk_tdata_o});
    end
    if (usb_tvalid_o && usb_tready_i) begin
      in_got_q.push_back({usb_tlast_o, usb_tkeep_o, usb_tdata_o});
    end
  end

  // NAKed packet must never reach the application
  always @(negedge clock) begin
    if (drain_check) begin
      check_value("out_nready blk_tvalid", 0, int'(blk_tvalid_o));
      check_value("out_nready usb_tready", 1, int'(usb_tready_o));
      check_value("out_nready store", 0, int'(blk_store_o));
    end
  end

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic send_token(input logic [1:0] kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    @(posedge clock);
    tok_recv_i <= 1'b1;
    tok_addr_i <= addr;
    tok_endp_i <= endp;
    usb_tuser_i <= {kind, usb_bulk_pkg::CLS_TOKEN};
    @(posedge clock);
    tok_recv_i <= 1'b0;
  endtask

  task automatic send_out_packet(input logic [1:0] kind, input int len, input bit app_ready);
    logic [7:0] b;
    int n;
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      usb_tvalid_i <= 1'b1;
      usb_tdata_i <= b;
      usb_tlast_i <= (i == len - 1);
      usb_tkeep_i <= 1'b1;
      usb_tuser_i <= {kind, usb_bulk_pkg::CLS_DATA};
      if (app_ready) out_exp_q.push_back({i == len - 1, 1'b1, b});
      n = 0;
      do begin
        @(posedge clock);
        n++;
      end while (!usb_tready_o && n < 100);
      if (!usb_tready_o) report_timeout("OUT beat acceptance");
    end
    usb_tvalid_i <= 1'b0;
    usb_tlast_i <= 1'b0;
    usb_recv_i <= 1'b1;
    @(posedge clock);
    usb_recv_i <= 1'b0;
  endtask

  task automatic send_in_packet(input int len);
    logic [7:0] b;
    int n;
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      blk_tvalid_i <= 1'b1;
      blk_tdata_i <= b;
      blk_tlast_i <= (i == len - 1);
      blk_tkeep_i <= 1'b1;
      in_exp_q.push_back({i == len - 1, 1'b1, b});
      n = 0;
      do begin
        @(posedge clock);
        n++;
      end while (!blk_tready_o && n < 100);
      if (!blk_tready_o) report_timeout("IN beat acceptance");
    end
    blk_tvalid_i <= 1'b0;
    blk_tlast_i <= 1'b0;
    pulse_usb_sent();
  endtask

  task automatic pulse_usb_sent();
    usb_sent_i <= 1'b1;
    @(posedge clock);
    usb_sent_i <= 1'b0;
  endtask

  task automatic receive_ack();
    @(posedge clock);
    hsk_recv_i <= 1'b1;
    usb_tuser_i <= {usb_bulk_pkg::HSK_ACK, usb_bulk_pkg::CLS_HSK};
    @(posedge clock);
    hsk_recv_i <= 1'b0;
  endtask

  // Counts edges from the usb_recv_i edge up to the handshake request and then sends it
  task automatic serve_handshake(input string name, input logic [1:0] kind);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!hsk_send_o && cycles < 100);
    if (!hsk_send_o) report_timeout("handshake request");
    check_value({name, " hsk delay"}, 7, cycles - 1);
    check_value({name, " hsk pid"}, int'({kind, usb_bulk_pkg::CLS_HSK}), int'(usb_tuser_o));
    @(posedge clock);
    hsk_sent_i <= 1'b1;
    @(posedge clock);
    hsk_sent_i <= 1'b0;
    @(negedge clock);
    check_value({name, " hsk release"}, 0, int'(hsk_send_o));
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!usb_device_idle_o && n < 50);
    if (!usb_device_idle_o) report_timeout("return to idle");
  endtask

  task automatic compare_streams(input string name, input bit is_in);
    if (is_in) begin
      check_value({name, " beats"}, in_exp_q.size(), in_got_q.size());
      foreach (in_exp_q[i]) if (i < in_got_q.size())
        check_value({name, " beat"}, int'(in_exp_q[i]), int'(in_got_q[i]));
    end else begin
      check_value({name, " beats"}, out_exp_q.size(), out_got_q.size());
      foreach (out_exp_q[i]) if (i < out_got_q.size())
        check_value({name, " beat"}, int'(out_exp_q[i]), int'(out_got_q[i]));
    end
    in_exp_q.delete();
    in_got_q.delete();
    out_exp_q.delete();
    out_got_q.delete();
  endtask

  initial begin
    int n;
    seed_val = $urandom(8);
    clock = 1'b0;
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_addr_i = '0;
    tok_endp_i = '0;
    usb_recv_i = 1'b0;
    usb_sent_i = 1'b0;
    hsk_recv_i = 1'b0;
    hsk_sent_i = 1'b0;
    config_event_i = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tkeep_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tuser_i = '0;
    usb_tdata_i = '0;
    usb_tready_i = 1'b0;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    blk_tready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tkeep_i = 1'b0;
    blk_tdata_i = '0;
    errors = 0;
    timeouts = 0;
    drain_check = 1'b0;
    exp_parity = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value("reset idle", 1, int'(usb_device_idle_o));
    check_value("reset parity", 0, int'(parity_o));

    // Bulk OUT with the application ready
    @(posedge clock);
    blk_out_ready_i <= 1'b1;
    send_token(usb_bulk_pkg::TOK_OUT, DEV_ADDR, BULK_EP);
    @(negedge clock);
    check_value("out_ready start", 1, int'(blk_start_o));
    check_value("out_ready store", 1, int'(blk_store_o));
    @(posedge clock);
    send_out_packet(usb_bulk_pkg::DATA0, 1 + int'($urandom % 8), 1'b1);
    serve_handshake("out_ready", usb_bulk_pkg::HSK_ACK);
    wait_idle();
    exp_parity = !exp_parity;
    check_value("out_ready parity", int'(exp_parity), int'(parity_o));
    compare_streams("out_ready", 1'b0);

    // Bulk OUT with the application not ready
    @(posedge clock);
    blk_out_ready_i <= 1'b0;
    send_token(usb_bulk_pkg::TOK_OUT, DEV_ADDR, BULK_EP);
    drain_check = 1'b1;
    send_out_packet(usb_bulk_pkg::DATA1, 1 + int'($urandom % 8), 1'b0);
    drain_check = 1'b0;
    serve_handshake("out_nready", usb_bulk_pkg::HSK_NAK);
    wait_idle();
    check_value("out_nready parity", int'(exp_parity), int'(parity_o));
    compare_streams("out_nready", 1'b0);

    // Bulk IN with data
    @(posedge clock);
    blk_in_ready_i <= 1'b1;
    send_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, BULK_EP);
    @(negedge clock);
    check_value("in_ready fetch", 1, int'(blk_fetch_o));
    check_value("in_ready pid", int'({exp_parity ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0,
                usb_bulk_pkg::CLS_DATA}), int'(usb_tuser_o));
    @(posedge clock);
    send_in_packet(1 + int'($urandom % 8));
    receive_ack();
    wait_idle();
    exp_parity = !exp_parity;
    check_value("in_ready parity", int'(exp_parity), int'(parity_o));
    compare_streams("in_ready", 1'b1);

    // Bulk IN without data gives a zero-data packet
    @(posedge clock);
    blk_in_ready_i <= 1'b0;
    send_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, BULK_EP);
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (in_got_q.size() == 0 && n < 100);
    if (in_got_q.size() == 0) report_timeout("zero-data packet");
    repeat (4) @(negedge clock);
    in_exp_q.push_back({1'b1, 1'b0, 8'h00});
    compare_streams("in_zdp", 1'b1);
    @(posedge clock);
    pulse_usb_sent();
    receive_ack();
    wait_idle();
    exp_parity = !exp_parity;

    // No handshake after an IN packet
    @(posedge clock);
    blk_in_ready_i <= 1'b1;
    send_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, BULK_EP);
    send_in_packet(1);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!usb_timeout_error_o && cycles < 400);
    if (!usb_timeout_error_o) report_timeout("turnaround timeout flag");
    check_value("timeout delay", 256, cycles - 1);
    wait_idle();
    check_value("timeout parity", int'(exp_parity), int'(parity_o));
    compare_streams("timeout", 1'b1);

    // Rejected tokens
    send_token(usb_bulk_pkg::TOK_SETUP, DEV_ADDR, BULK_EP);
    @(negedge clock);
    check_value("setup err", int'(usb_bulk_pkg::ER_TOKN), int'(err_code_o));
    send_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, 4'd3);
    @(negedge clock);
    check_value("endp err", int'(usb_bulk_pkg::ER_ENDP), int'(err_code_o));
    check_value("endp start", 0, int'(blk_start_o));
    send_token(usb_bulk_pkg::TOK_OUT, DEV_ADDR + 7'd1, BULK_EP);
    @(negedge clock);
    check_value("addr err", int'(usb_bulk_pkg::ER_NONE), int'(err_code_o));
    check_value("addr start", 0, int'(blk_start_o));
    check_value("addr idle", 1, int'(usb_device_idle_o));

    // Configuration clears the toggle
    check_value("config before", 1, int'(parity_o));
    @(posedge clock);
    config_event_i <= 1'b1;
    @(posedge clock);
    config_event_i <= 1'b0;
    @(negedge clock);
    check_value("config parity", 0, int'(parity_o));

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #500000;
    $display("Simulation ran too long and was stopped");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- usb_bulk_transactor.f
usb_bulk_pkg.sv
bulk_state_if.sv
bulk_transfer_fsm.sv
data_toggle.sv
eop_handshake.sv
turnaround_timer.sv
tx_stream_mux.sv
usb_bulk_transactor.sv
usb_bulk_transactor_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_bulk_transactor_tb \
  -f usb_bulk_transactor.f -o sim_tb || exit 1
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" && exit 0 || exit 1
